//--- axil_csr_top.f
+incdir+hdl
hdl/axil_csr_pkg.sv
hdl/fifo2.sv
hdl/axil_to_avmm_rdwr.sv
hdl/csr_regfile_avmm.sv
hdl/axil_csr_top.sv
bench/axil_csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the CSR testbench with Verilator, runs it, and looks for the pass message in the log

TOP=axil_csr_tb
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module "$TOP" -f axil_csr_top.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q -F "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation run passed"
    exit 0
else
    echo "Simulation run failed, see $LOG"
    exit 1
fi

//--- bench/axil_csr_tb.sv
// ====================
// Table-driven testbench for the AXI-lite CSR subsystem with a register file model
// Run it through the file list with the testbench as top module
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "axil_csr_macros.svh"

module axil_csr_tb;

    localparam int TIMEOUT_CYCLES = 50;
    localparam logic [1:0] OP_RD   = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_WRRD = 2'd2;
    localparam axil_csr_pkg::axil_resp_t OK  = axil_csr_pkg::OKAY;
    localparam axil_csr_pkg::axil_resp_t ERR = axil_csr_pkg::SLVERR;

    // One table row, with the response it should produce
    typedef struct packed {
        logic [1:0]               op;
        logic [`AXIL_ADDR_W-1:0]  addr;
        logic [2:0]               size;
        logic [`AXIL_ID_W-1:0]    id;
        logic [`AXIL_DATA_W-1:0]  data;
        logic [`AXIL_STRB_W-1:0]  strb;
        logic [3:0]               hold;
        axil_csr_pkg::axil_resp_t resp;
    } step_t;

    logic clk, reset_n;
    logic arvalid, arready, awvalid, awready, wvalid, wready;
    logic rvalid, rready, bvalid, bready;
    axil_csr_pkg::axil_ar_t ar;
    axil_csr_pkg::axil_aw_t aw;
    axil_csr_pkg::axil_w_t  w;
    axil_csr_pkg::axil_r_t  r;
    axil_csr_pkg::axil_b_t  b;

    step_t                   steps[$];
    axil_csr_pkg::axil_b_t   b_seen[$];
    logic [`AXIL_DATA_W-1:0] model [`CSR_DEPTH];
    logic [31:0]             rng_state;
    int                      error_count;
    int                      timeout_count;

    axil_csr_top DUT (
        .clk, .reset_n,
        .arvalid, .arready, .ar, .awvalid, .awready, .aw, .wvalid, .wready, .w,
        .rvalid, .rready, .r, .bvalid, .bready, .b
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // bvalid is a one-cycle pulse, so every pulse is caught mid-cycle
    always @(negedge clk)
    begin
        if (reset_n && bvalid)
            b_seen.push_back(b);
    end

    // ====================
    // Reference model
    // ====================

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic in_range(input logic [`AXIL_ADDR_W-1:0] addr);
        return addr[`AXIL_ADDR_W-1:2] < `AVMM_ADDR_W'(`CSR_DEPTH);
    endfunction

    // Lanes from the byte offset up, 1, 2 or 4 bytes wide, cut off at the top lane
    function automatic logic [3:0] read_lanes(input logic [`AXIL_ADDR_W-1:0] addr,
                                              input logic [2:0] size);
        int         nbytes;
        int         off;
        logic [3:0] lanes;
        nbytes = (size >= 3'd2) ? 4 : (1 << size);
        off    = int'(addr[1:0]);
        lanes  = '0;
        for (int i = 0; i < 4; i++)
            lanes[i] = (i >= off) && (i < off + nbytes);
        return lanes;
    endfunction

    function automatic logic [31:0] model_read(input logic [`AXIL_ADDR_W-1:0] addr,
                                               input logic [2:0] size);
        logic [31:0] word;
        logic [3:0]  lanes;
        if (!in_range(addr))
            return '0;
        word  = model[addr[2 +: 8]];
        lanes = read_lanes(addr, size);
        for (int i = 0; i < 4; i++)
        begin
            if (!lanes[i])
                word[8*i +: 8] = 8'h00;
        end
        return word;
    endfunction

    function automatic void model_write(input logic [`AXIL_ADDR_W-1:0] addr,
                                        input logic [31:0] data, input logic [3:0] strb);
        if (in_range(addr))
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (strb[i])
                    model[addr[2 +: 8]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    function automatic step_t make_step(input logic [1:0] op,
                                        input logic [`AXIL_ADDR_W-1:0] addr,
                                        input logic [2:0] size, input logic [3:0] id,
                                        input logic [31:0] data, input logic [3:0] strb,
                                        input logic [3:0] hold,
                                        input axil_csr_pkg::axil_resp_t resp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.size = size;
        s.id   = id;
        s.data = data;
        s.strb = strb;
        s.hold = hold;
        s.resp = resp;
        return s;
    endfunction

    // ====================
    // Checks and run control
    // ====================

    task automatic finish_run();
        $display("Errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: gave up waiting for %s after %0d cycles",
                 $time, what, TIMEOUT_CYCLES);
        timeout_count++;
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // Inputs always change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // ====================
    // Bus tasks
    // ====================

    // Each channel drops its valid right after its own handshake edge
    task automatic issue_req(input logic do_rd, input logic do_wr, input step_t s);
        int   n;
        logic ar_left, aw_left, w_left;
        logic ar_go, aw_go, w_go;
        ar.addr = s.addr;
        ar.size = s.size;
        ar.id   = s.id;
        aw.addr = s.addr;
        aw.id   = s.id;
        w.data  = s.data;
        w.strb  = s.strb;
        arvalid = do_rd;
        awvalid = do_wr;
        wvalid  = do_wr;
        ar_left = do_rd;
        aw_left = do_wr;
        w_left  = do_wr;
        n = 0;
        while ((ar_left || aw_left || w_left) && n < TIMEOUT_CYCLES)
        begin
            ar_go = ar_left && arready;
            aw_go = aw_left && awready;
            w_go  = w_left && wready;
            next_cycle();
            if (ar_go)
            begin
                ar_left = 1'b0;
                arvalid = 1'b0;
            end
            if (aw_go)
            begin
                aw_left = 1'b0;
                awvalid = 1'b0;
            end
            if (w_go)
            begin
                w_left = 1'b0;
                wvalid = 1'b0;
            end
            n++;
        end
        if (ar_left || aw_left || w_left)
            report_timeout("arready, awready or wready");
    endtask

    // The cycle right after the handshake edge counts as cycle 1
    task automatic collect_r(input logic [31:0] exp_data, input axil_csr_pkg::axil_resp_t exp_resp,
                             input logic [3:0] exp_id, input int hold, input logic check_lat);
        int                    n;
        axil_csr_pkg::axil_r_t held;
        n = 1;
        while (!rvalid && n < TIMEOUT_CYCLES)
        begin
            next_cycle();
            n++;
        end
        if (!rvalid)
            report_timeout("rvalid");
        else
        begin
            if (check_lat)
                check_value("rvalid latency", 32'd3, 32'(n));
            check_value("r.data", exp_data, r.data);
            check_value("r.resp", 32'(exp_resp), 32'(r.resp));
            check_value("r.id", 32'(exp_id), 32'(r.id));
            held = r;
            // While rready stays low, the response must not move
            repeat (hold)
            begin
                next_cycle();
                check_value("rvalid", 32'd1, 32'(rvalid));
                check_value("r.data", held.data, r.data);
                check_value("r.resp", 32'(held.resp), 32'(r.resp));
                check_value("r.id", 32'(held.id), 32'(r.id));
            end
            rready = 1'b1;
            next_cycle();
            rready = 1'b0;
        end
    endtask

    task automatic wait_b(input axil_csr_pkg::axil_resp_t exp_resp, input logic [3:0] exp_id);
        int                    n;
        axil_csr_pkg::axil_b_t got;
        n = 0;
        while (b_seen.size() == 0 && n < TIMEOUT_CYCLES)
        begin
            next_cycle();
            n++;
        end
        if (b_seen.size() == 0)
            report_timeout("bvalid");
        else
        begin
            got = b_seen.pop_front();
            check_value("b.resp", 32'(exp_resp), 32'(got.resp));
            check_value("b.id", 32'(exp_id), 32'(got.id));
        end
    endtask

    // A paired read is accepted before the write lands, so it returns the old word
    task automatic run_step(input step_t s);
        logic [31:0] exp_rd;
        exp_rd = model_read(s.addr, s.size);
        case (s.op)
            OP_RD:
            begin
                issue_req(1'b1, 1'b0, s);
                collect_r(exp_rd, s.resp, s.id, int'(s.hold), 1'b1);
            end
            OP_WR:
            begin
                issue_req(1'b0, 1'b1, s);
                model_write(s.addr, s.data, s.strb);
                wait_b(s.resp, s.id);
            end
            default:
            begin
                issue_req(1'b1, 1'b1, s);
                model_write(s.addr, s.data, s.strb);
                collect_r(exp_rd, s.resp, s.id, int'(s.hold), 1'b1);
                wait_b(s.resp, s.id);
            end
        endcase
    endtask

    // ====================
    // Scenarios
    // ====================

    task automatic build_table();
        // Fresh words read back as zero
        steps.push_back(make_step(OP_RD, 12'h000, 3'd2, 4'h1, 32'h0, 4'h0, 4'd0, OK));
        steps.push_back(make_step(OP_RD, 12'h3FC, 3'd2, 4'h2, 32'h0, 4'h0, 4'd0, OK));
        // full word write then readback
        steps.push_back(make_step(OP_WR, 12'h010, 3'd2, 4'h3, 32'hA5A5_1234, 4'hF, 4'd0, OK));
        steps.push_back(make_step(OP_RD, 12'h010, 3'd2, 4'h4, 32'h0, 4'h0, 4'd0, OK));
        // Byte merges, then narrow reads at every offset
        steps.push_back(make_step(OP_WR, 12'h020, 3'd2, 4'h5, 32'h1122_3344, 4'hF, 4'd0, OK));
        steps.push_back(make_step(OP_WR, 12'h020, 3'd2, 4'h6, 32'hAABB_CCDD, 4'b0101, 4'd0, OK));
        for (int k = 0; k < 8; k++)
            steps.push_back(make_step(OP_RD, 12'h020 + 12'(k % 4), 3'(k / 4), 4'(7 + k),
                                      32'h0, 4'h0, 4'd0, OK));
        steps.push_back(make_step(OP_WRRD, 12'h024, 3'd2, 4'hF, 32'h55AA_55AA, 4'b1100, 4'd0, OK));
        steps.push_back(make_step(OP_RD, 12'h024, 3'd2, 4'h0, 32'h0, 4'h0, 4'd0, OK));
        // Words past the register file answer SLVERR and must not alias onto low words
        steps.push_back(make_step(OP_WR, 12'h400, 3'd2, 4'h1, 32'hDEAD_BEEF, 4'hF, 4'd0, ERR));
        steps.push_back(make_step(OP_WR, 12'hFFC, 3'd2, 4'h2, 32'hCAFE_F00D, 4'hF, 4'd0, ERR));
        steps.push_back(make_step(OP_RD, 12'h400, 3'd2, 4'h3, 32'h0, 4'h0, 4'd0, ERR));
        steps.push_back(make_step(OP_RD, 12'h801, 3'd0, 4'h4, 32'h0, 4'h0, 4'd0, ERR));
        steps.push_back(make_step(OP_RD, 12'h000, 3'd2, 4'h5, 32'h0, 4'h0, 4'd0, OK));
        steps.push_back(make_step(OP_RD, 12'h3FC, 3'd2, 4'h6, 32'h0, 4'h0, 4'd0, OK));
        // Response held while rready stays low
        steps.push_back(make_step(OP_RD, 12'h010, 3'd2, 4'h7, 32'h0, 4'h0, 4'd6, OK));
    endtask

    // First read stalls on r, the next two fill the AR FIFO
    task automatic queued_reads();
        logic [`AXIL_ADDR_W-1:0] addrs[3];
        addrs[0] = 12'h010;
        addrs[1] = 12'h020;
        addrs[2] = 12'h024;
        for (int k = 0; k < 3; k++)
            issue_req(1'b1, 1'b0, make_step(OP_RD, addrs[k], 3'd2, 4'(5 + k), 32'h0, 4'h0,
                                            4'd0, OK));
        check_value("arready", 32'd0, 32'(arready));
        for (int k = 0; k < 3; k++)
            collect_r(model_read(addrs[k], 3'd2), OK, 4'(5 + k), (k == 0) ? 4 : 0, 1'b0);
    endtask

    task automatic random_writes();
        step_t                   s;
        logic [31:0]             rnd;
        logic [3:0]              ids[$];
        logic [`AXIL_ADDR_W-1:0] addrs[$];
        for (int k = 0; k < 8; k++)
        begin
            rnd = next_random();
            s = make_step(OP_WR, {2'b00, rnd[7:0], 2'b00}, 3'd2, rnd[11:8], next_random(),
                          4'hF, 4'd0, OK);
            issue_req(1'b0, 1'b1, s);
            model_write(s.addr, s.data, s.strb);
            ids.push_back(s.id);
            addrs.push_back(s.addr);
        end
        // Responses arrive in issue order
        foreach (ids[k])
            wait_b(OK, ids[k]);
        foreach (addrs[k])
            run_step(make_step(OP_RD, addrs[k], 3'd2, 4'(k), 32'h0, 4'h0, 4'd0, OK));
    endtask

    initial
    begin
        reset_n       = 1'b0;
        arvalid       = 1'b0;
        awvalid       = 1'b0;
        wvalid        = 1'b0;
        rready        = 1'b0;
        bready        = 1'b1;
        ar            = '0;
        aw            = '0;
        w             = '0;
        error_count   = 0;
        timeout_count = 0;
        rng_state     = 32'h57dd;
        for (int i = 0; i < `CSR_DEPTH; i++)
            model[i] = '0;
        build_table();

        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // Idle state straight out of reset
        check_value("rvalid", 32'd0, 32'(rvalid));
        check_value("bvalid", 32'd0, 32'(bvalid));
        check_value("arready", 32'd1, 32'(arready));
        check_value("awready", 32'd1, 32'(awready));
        check_value("wready", 32'd1, 32'(wready));

        foreach (steps[k])
            run_step(steps[k]);
        queued_reads();
        random_writes();

        // Any leftover entry is a bvalid pulse that no write asked for
        check_value("extra bvalid pulses", 32'd0, 32'(b_seen.size()));
        finish_run();
    end

endmodule

`default_nettype wire

//--- hdl/axil_csr_top.sv
// ====================
// CSR subsystem top, an AXI-lite port in front of a 256-word register file
// ====================

`timescale 1ns/1ps
`default_nettype none

module axil_csr_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   arvalid,
    output logic                   arready,
    input  axil_csr_pkg::axil_ar_t ar,
    input  logic                   awvalid,
    output logic                   awready,
    input  axil_csr_pkg::axil_aw_t aw,
    input  logic                   wvalid,
    output logic                   wready,
    input  axil_csr_pkg::axil_w_t  w,
    output logic                   rvalid,
    input  logic                   rready,
    output axil_csr_pkg::axil_r_t  r,
    output logic                   bvalid,
    // Write responses cannot be stalled, so this input goes nowhere
    input  logic                   bready,
    output axil_csr_pkg::axil_b_t  b
);

    // Split Avalon bus between the bridge and the register file
    logic                       rd_read, rd_waitrequest, rd_readdatavalid;
    logic                       wr_write, wr_waitrequest, wr_writeresponsevalid;
    axil_csr_pkg::avmm_rd_req_t rd_req;
    axil_csr_pkg::avmm_rd_rsp_t rd_rsp;
    axil_csr_pkg::avmm_wr_req_t wr_req;
    axil_csr_pkg::avmm_wr_rsp_t wr_rsp;

    // Read IDs are regenerated inside the bridge
    axil_to_avmm_rdwr #(.GEN_RD_RESPONSE_METADATA(1)) bridge (
        .clk, .reset_n,
        .arvalid, .arready, .ar, .awvalid, .awready, .aw, .wvalid, .wready, .w,
        .rvalid, .rready, .r, .bvalid, .b,
        .rd_read, .rd_req, .rd_waitrequest, .rd_readdatavalid, .rd_rsp,
        .wr_write, .wr_req, .wr_waitrequest, .wr_writeresponsevalid, .wr_rsp
    );

    csr_regfile_avmm regfile (
        .clk, .reset_n,
        .rd_read, .rd_req, .rd_waitrequest, .rd_readdatavalid, .rd_rsp,
        .wr_write, .wr_req, .wr_waitrequest, .wr_writeresponsevalid, .wr_rsp
    );

endmodule

`default_nettype wire

//--- hdl/csr_regfile_avmm.sv
// ====================
// Register file sink on a split Avalon read/write bus, with byte masks
// Words past the implemented depth answer SLVERR
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "axil_csr_macros.svh"

module csr_regfile_avmm (
    input  logic                       clk,
    input  logic                       reset_n,
    // Read side
    input  logic                       rd_read,
    input  axil_csr_pkg::avmm_rd_req_t rd_req,
    output logic                       rd_waitrequest,
    output logic                       rd_readdatavalid,
    output axil_csr_pkg::avmm_rd_rsp_t rd_rsp,
    // Write side
    input  logic                       wr_write,
    input  axil_csr_pkg::avmm_wr_req_t wr_req,
    output logic                       wr_waitrequest,
    output logic                       wr_writeresponsevalid,
    output axil_csr_pkg::avmm_wr_rsp_t wr_rsp
);

    localparam int IDX_W = $clog2(`CSR_DEPTH);

    logic [`AXIL_DATA_W-1:0] mem [`CSR_DEPTH];
    logic                    rd_in_range;
    logic                    wr_in_range;
    logic                    wr_accept;
    logic [`AXIL_DATA_W-1:0] rd_word;

    // Reads are never stalled
    assign rd_waitrequest = 1'b0;
    assign wr_accept      = wr_write && !wr_waitrequest;

    assign rd_in_range = rd_req.address < `AVMM_ADDR_W'(`CSR_DEPTH);
    assign wr_in_range = wr_req.address < `AVMM_ADDR_W'(`CSR_DEPTH);

    // Read data with disabled lanes zeroed, and all zero when out of range
    always_comb
    begin
        rd_word = mem[rd_req.address[IDX_W-1:0]];
        for (int i = 0; i < `AXIL_STRB_W; i++)
        begin
            if (!rd_req.byteenable[i])
                rd_word[8*i +: 8] = 8'h00;
        end
        if (!rd_in_range)
            rd_word = '0;
    end

    // ====================
    // Storage and handshakes
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < `CSR_DEPTH; i++)
                mem[i] <= '0;
            rd_readdatavalid      <= 1'b0;
            wr_writeresponsevalid <= 1'b0;
            wr_waitrequest        <= 1'b0;
        end
        else
        begin
            rd_readdatavalid      <= rd_read;
            wr_writeresponsevalid <= wr_accept;
            // One idle cycle after every accepted write
            wr_waitrequest        <= wr_accept;

            // Only enabled byte lanes change, and out-of-range writes are dropped
            if (wr_accept && wr_in_range)
            begin
                for (int i = 0; i < `AXIL_STRB_W; i++)
                begin
                    if (wr_req.byteenable[i])
                        mem[wr_req.address[IDX_W-1:0]][8*i +: 8] <= wr_req.writedata[8*i +: 8];
                end
            end
        end
    end

    // Response payloads echo the request's user field
    always_ff @(posedge clk)
    begin
        if (rd_read)
        begin
            rd_rsp.readdata <= rd_word;
            rd_rsp.response <= rd_in_range ? axil_csr_pkg::OKAY : axil_csr_pkg::SLVERR;
            rd_rsp.user     <= rd_req.user;
        end
        if (wr_accept)
        begin
            wr_rsp.response <= wr_in_range ? axil_csr_pkg::OKAY : axil_csr_pkg::SLVERR;
            wr_rsp.user     <= wr_req.user;
        end
    end

endmodule

`default_nettype wire

//--- hdl/axil_to_avmm_rdwr.sv
// ====================
// AXI-lite slave to split Avalon read/write master bridge
// One read in flight at a time, and write responses cannot be stalled
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "axil_csr_macros.svh"

module axil_to_avmm_rdwr #(
    // When set, the read ID is taken from a copy saved at issue time
    parameter int GEN_RD_RESPONSE_METADATA = 0
) (
    input  logic                       clk,
    input  logic                       reset_n,
    // AXI-lite side
    input  logic                       arvalid,
    output logic                       arready,
    input  axil_csr_pkg::axil_ar_t     ar,
    input  logic                       awvalid,
    output logic                       awready,
    input  axil_csr_pkg::axil_aw_t     aw,
    input  logic                       wvalid,
    output logic                       wready,
    input  axil_csr_pkg::axil_w_t      w,
    output logic                       rvalid,
    input  logic                       rready,
    output axil_csr_pkg::axil_r_t      r,
    output logic                       bvalid,
    output axil_csr_pkg::axil_b_t      b,
    // Avalon side
    output logic                       rd_read,
    output axil_csr_pkg::avmm_rd_req_t rd_req,
    input  logic                       rd_waitrequest,
    input  logic                       rd_readdatavalid,
    input  axil_csr_pkg::avmm_rd_rsp_t rd_rsp,
    output logic                       wr_write,
    output axil_csr_pkg::avmm_wr_req_t wr_req,
    input  logic                       wr_waitrequest,
    input  logic                       wr_writeresponsevalid,
    input  axil_csr_pkg::avmm_wr_rsp_t wr_rsp
);

    // Byte-offset bits that are dropped from AXI addresses
    localparam int BYTE_OFF_W = `AXIL_ADDR_W - `AVMM_ADDR_W;

    // ====================
    // Reads
    // ====================

    axil_csr_pkg::axil_ar_t ar_head;
    logic                   ar_pending;
    logic                   rd_busy;
    logic                   fwd_rd_req;
    logic [`AXIL_ID_W-1:0]  rd_saved_id;

    // The FIFO matches the delay of the write path so that ordering is not made worse
    fifo2 #(.T(axil_csr_pkg::axil_ar_t)) ar_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (ar),
        .enq_en    (arvalid && arready),
        .not_full  (arready),
        .first     (ar_head),
        .deq_en    (fwd_rd_req),
        .not_empty (ar_pending)
    );

    // A read leaves the FIFO only when nothing is waiting on the r channel
    assign rd_read    = ar_pending && !rd_busy;
    assign fwd_rd_req = rd_read && !rd_waitrequest;

    always_comb
    begin
        rd_req.address    = ar_head.addr[BYTE_OFF_W +: `AVMM_ADDR_W];
        // Size mask moved up to the addressed byte lane
        rd_req.byteenable = `AXIL_STRB_W'(axil_csr_pkg::size_to_mask(ar_head.size) <<
                                          ar_head.addr[BYTE_OFF_W-1:0]);
        rd_req.user       = ar_head.id;
    end

    // Busy runs from issue until the r handshake, and rvalid holds until rready
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_busy <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            if (rvalid && rready)
            begin
                rd_busy <= 1'b0;
                rvalid  <= 1'b0;
            end
            else if (fwd_rd_req)
                rd_busy <= 1'b1;

            if (rd_readdatavalid)
                rvalid <= 1'b1;
        end
    end

    // Response payload, registered once and held while rvalid waits
    always_ff @(posedge clk)
    begin
        if (fwd_rd_req)
            rd_saved_id <= ar_head.id;

        if (rd_readdatavalid)
        begin
            r.data <= rd_rsp.readdata;
            r.resp <= rd_rsp.response;
            r.id   <= (GEN_RD_RESPONSE_METADATA != 0) ? rd_saved_id : rd_rsp.user;
        end
    end

    // ====================
    // Writes
    // ====================

    axil_csr_pkg::axil_aw_t aw_head;
    axil_csr_pkg::axil_w_t  w_head;
    logic                   aw_pending;
    logic                   w_pending;
    logic                   fwd_wr_req;

    fifo2 #(.T(axil_csr_pkg::axil_aw_t)) aw_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (aw),
        .enq_en    (awvalid && awready),
        .not_full  (awready),
        .first     (aw_head),
        .deq_en    (fwd_wr_req),
        .not_empty (aw_pending)
    );

    fifo2 #(.T(axil_csr_pkg::axil_w_t)) w_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (w),
        .enq_en    (wvalid && wready),
        .not_full  (wready),
        .first     (w_head),
        .deq_en    (fwd_wr_req),
        .not_empty (w_pending)
    );

    // Address and data are merged into one Avalon write, both popped together
    assign wr_write   = aw_pending && w_pending;
    assign fwd_wr_req = wr_write && !wr_waitrequest;

    always_comb
    begin
        wr_req.address    = aw_head.addr[BYTE_OFF_W +: `AVMM_ADDR_W];
        wr_req.writedata  = w_head.data;
        wr_req.byteenable = w_head.strb;
        wr_req.user       = aw_head.id;

        // No buffering here, so b can never be stalled
        bvalid = wr_writeresponsevalid;
        b.resp = wr_rsp.response;
        b.id   = wr_rsp.user;
    end

endmodule

`default_nettype wire

//--- hdl/fifo2.sv
// ====================
// Two-entry FIFO for one payload type, used to decouple AXI channels
// ====================

`timescale 1ns/1ps
`default_nettype none

module fifo2 #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset_n,
    input  T     enq_data,
    input  logic enq_en,
    output logic not_full,
    output T     first,
    input  logic deq_en,
    output logic not_empty
);

    // Slot 0 is always the oldest entry and slot 1 only fills behind it
    T     data0, data1;
    logic valid0, valid1;

    assign first     = data0;
    assign not_empty = valid0;
    // Ready only while the second slot is free
    assign not_full  = !valid1;

    // Valid flags
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else if (deq_en)
        begin
            // Slot 0 refills from slot 1 or directly from the incoming entry
            valid0 <= valid1 || enq_en;
            valid1 <= valid1 && enq_en;
        end
        else if (enq_en)
        begin
            valid0 <= 1'b1;
            valid1 <= valid0;
        end
    end

    // Payload slots, steered the same way as the flags
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            data0 <= valid1 ? data1 : enq_data;
            data1 <= enq_data;
        end
        else if (enq_en)
        begin
            if (!valid0)
                data0 <= enq_data;
            else
                data1 <= enq_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/axil_csr_pkg.sv
// ====================
// Channel types and helpers for the AXI-lite to Avalon CSR subsystem
// ====================

`default_nettype none

`include "axil_csr_macros.svh"

package axil_csr_pkg;

    // AXI response codes, which match the Avalon response encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    // ====================
    // AXI-lite channel payloads
    // ====================

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [2:0]              size;
        logic [`AXIL_ID_W-1:0]   id;
    } axil_ar_t;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
        logic [`AXIL_ID_W-1:0]   id;
    } axil_aw_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_STRB_W-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        axil_resp_t              resp;
        logic [`AXIL_ID_W-1:0]   id;
    } axil_r_t;

    typedef struct packed {
        axil_resp_t            resp;
        logic [`AXIL_ID_W-1:0] id;
    } axil_b_t;

    // ====================
    // Avalon split read/write payloads
    // ====================

    // The user field holds only the AXI ID
    typedef struct packed {
        logic [`AVMM_ADDR_W-1:0] address;
        logic [`AXIL_STRB_W-1:0] byteenable;
        logic [`AXIL_ID_W-1:0]   user;
    } avmm_rd_req_t;

    typedef struct packed {
        logic [`AVMM_ADDR_W-1:0] address;
        logic [`AXIL_DATA_W-1:0] writedata;
        logic [`AXIL_STRB_W-1:0] byteenable;
        logic [`AXIL_ID_W-1:0]   user;
    } avmm_wr_req_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] readdata;
        axil_resp_t              response;
        logic [`AXIL_ID_W-1:0]   user;
    } avmm_rd_rsp_t;

    typedef struct packed {
        axil_resp_t            response;
        logic [`AXIL_ID_W-1:0] user;
    } avmm_wr_rsp_t;

    // Turn an AXI beat size into a mask of the low bytes that it covers
    // Anything from size 2 upward covers the whole bus
    function automatic logic [`AXIL_STRB_W-1:0] size_to_mask(input logic [2:0] size);
        case (size)
            3'd0:    return `AXIL_STRB_W'(1);
            3'd1:    return `AXIL_STRB_W'(3);
            default: return '1;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hdl/axil_csr_macros.svh
// ====================
// Widths and depths shared by the CSR package, the RTL and the testbench
// Include this header wherever one of these sizes is needed
// ====================

`ifndef AXIL_CSR_MACROS_SVH
`define AXIL_CSR_MACROS_SVH

// AXI-lite byte address width, giving a 4 KB register window
`define AXIL_ADDR_W 12
// Data bus width in bits and the matching number of byte lanes
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4
// Transaction ID width, carried through the Avalon user field
`define AXIL_ID_W 4

// Avalon word address, which is the AXI address minus the 2 byte-offset bits
`define AVMM_ADDR_W 10
// Number of words that the register file actually implements
`define CSR_DEPTH 256

`endif
